// File: Makefile
VERILATOR ?= verilator
TOP       ?= mul_tb
FLIST     ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/mul_tb.sv
`timescale 1ns/10ps

module mul_tb;
	import mul_pkg::*;

	localparam int    XLEN            = 64;
	localparam int    NUM_RAND        = 20;
	localparam int    NUM_DIRECTED    = 8;
	localparam int    CYCLES_PER_TEST = 20;
	localparam int    TIMEOUT_MARGIN  = 100;
	localparam string TRACE_PATH      = "dv/mul_trace.txt";

	logic            clk;
	logic            rst_n;
	logic            wb_cyc;
	logic            wb_stb;
	logic            wb_we;
	logic [5:0]      wb_adr;
	logic [XLEN-1:0] wb_dat_w;
	logic [XLEN-1:0] wb_dat_r;
	logic            wb_ack;

	string           t_name[$];
	logic [2:0]      t_op[$];
	logic [XLEN-1:0] t_a[$];
	logic [XLEN-1:0] t_b[$];
	logic [XLEN-1:0] t_hi[$];
	logic [XLEN-1:0] t_lo[$];

	int limit = 0;
	int cycles;
	int ack_wait;
	int seed;

	mul_top #(.XLEN(XLEN)) dut_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check(input string name, input logic [XLEN-1:0] expected,
			input logic [XLEN-1:0] actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "check failed");
		end
	endtask

	// ack is sampled on the falling edge, away from the DUT's updates.
	task automatic wait_ack();
		ack_wait = 0;
		do begin
			@(negedge clk);
			ack_wait++;
		end while (wb_ack !== 1'b1);
	endtask

	task automatic wb_write(input logic [5:0] adr, input logic [XLEN-1:0] data);
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_adr   <= adr;
		wb_dat_w <= data;
		wait_ack();
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_read(input logic [5:0] adr, output logic [XLEN-1:0] data);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we  <= 1'b0;
		wb_adr <= adr;
		wait_ack();
		data = wb_dat_r;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	function automatic logic [XLEN-1:0] control_word(input mul_op_e opc, input logic go,
			input logic clear);
		logic [XLEN-1:0] w;
		w             = '0;
		w[2:0]        = opc;
		w[CTRL_START] = go;
		w[CTRL_FLUSH] = clear;
		return w;
	endfunction

	// exact product of both operands, each extended by the opcode's signedness.
	function automatic logic [2*XLEN-1:0] reference_product(input mul_op_e opc,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [XLEN-1:0]   sa;
		logic [XLEN-1:0]   sb;
		logic              a_signed;
		logic              b_signed;
		logic [2*XLEN-1:0] ext_a;
		logic [2*XLEN-1:0] ext_b;
		sa       = a;
		sb       = b;
		a_signed = (opc != MUL_HUU);
		b_signed = (opc != MUL_HUU) && (opc != MUL_HSU);
		if (opc == MUL_W) begin
			sa = {{(XLEN/2){a[XLEN/2-1]}}, a[XLEN/2-1:0]};
			sb = {{(XLEN/2){b[XLEN/2-1]}}, b[XLEN/2-1:0]};
		end
		ext_a = {{XLEN{a_signed & sa[XLEN-1]}}, sa};
		ext_b = {{XLEN{b_signed & sb[XLEN-1]}}, sb};
		return ext_a * ext_b;
	endfunction

	task automatic start_product(input mul_op_e opc, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		wb_write(ADR_OP1, a);
		wb_write(ADR_OP2, b);
		wb_write(ADR_CTRL, control_word(opc, 1'b1, 1'b0));
	endtask

	task automatic check_results(input string name, input logic [XLEN-1:0] exp_hi,
			input logic [XLEN-1:0] exp_lo);
		logic [XLEN-1:0] got;
		wb_read(ADR_RES_LO, got);
		check({name, " lo"}, exp_lo, got);
		wb_read(ADR_RES_HI, got);
		check({name, " hi"}, exp_hi, got);
	endtask

	task automatic run_reference(input string name, input mul_op_e opc,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [2*XLEN-1:0] prod;
		prod = reference_product(opc, a, b);
		start_product(opc, a, b);
		check_results(name, prod[2*XLEN-1:XLEN], prod[XLEN-1:0]);
	endtask

	// lines starting with # are comments.
	task automatic read_trace();
		int              fd;
		int              n;
		int              opc;
		string           line;
		string           nm;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] hi;
		logic [XLEN-1:0] lo;
		fd = $fopen(TRACE_PATH, "r");
		if (fd == 0) begin
			$display("could not open the trace file %s", TRACE_PATH);
			$display("*** FAILED ***");
			$fatal(1, "no trace");
		end
		while (!$feof(fd)) begin
			line = "";
			n    = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
				n = $sscanf(line, "%s %d %h %h %h %h", nm, opc, a, b, hi, lo);
				if (n == 6) begin
					t_name.push_back(nm);
					t_op.push_back(opc[2:0]);
					t_a.push_back(a);
					t_b.push_back(b);
					t_hi.push_back(hi);
					t_lo.push_back(lo);
				end
			end
		end
		$fclose(fd);
	endtask

	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: bus did not acknowledge");
		$display("*** FAILED ***");
		$fatal(1, "timeout");
	end

	initial begin
		logic [XLEN-1:0]   got;
		logic [XLEN-1:0]   a;
		logic [XLEN-1:0]   b;
		logic [2*XLEN-1:0] prod;
		mul_op_e           opc;
		rst_n    <= 1'b0;
		wb_cyc   <= 1'b0;
		wb_stb   <= 1'b0;
		wb_we    <= 1'b0;
		wb_adr   <= '0;
		wb_dat_w <= '0;
		seed = 35;
		read_trace();
		if (t_name.size() == 0) begin
			$display("the trace file holds no tests");
			$display("*** FAILED ***");
			$fatal(1, "empty trace");
		end
		limit = (t_name.size() + NUM_RAND + NUM_DIRECTED) * CYCLES_PER_TEST + TIMEOUT_MARGIN;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		// nothing has run yet, so status and results read zero.
		wb_read(ADR_STATUS, got);
		check("reset status", '0, got);
		wb_read(ADR_RES_LO, got);
		check("reset res_lo", '0, got);
		wb_read(ADR_RES_HI, got);
		check("reset res_hi", '0, got);

		foreach (t_name[i]) begin
			start_product(mul_op_e'(t_op[i]), t_a[i], t_b[i]);
			check_results(t_name[i], t_hi[i], t_lo[i]);
		end

		// result read straight after start must stall.
		a    = 64'h0000_0123_4567_89ab;
		b    = 64'hffff_ffff_ffff_fff3;
		prod = reference_product(MUL_HSS, a, b);
		start_product(MUL_HSS, a, b);
		check_results("stalled read", prod[2*XLEN-1:XLEN], prod[XLEN-1:0]);
		wb_read(ADR_STATUS, got);
		check("status after read", 64'h2, got);
		prod = reference_product(MUL_HUU, b, a);
		start_product(MUL_HUU, b, a);
		wb_read(ADR_STATUS, got);
		check("status while busy", 64'h1, got);
		wb_read(ADR_RES_LO, got);
		check("result after busy", prod[XLEN-1:0], got);
		prod = reference_product(MUL_HSS, a, b);
		start_product(MUL_HSS, a, b);
		wb_read(ADR_RES_LO, got);
		// an unstalled read sees ack on its second falling edge.
		check("stall on result read", 64'h1, XLEN'(ack_wait > 2));
		check("stalled result", prod[XLEN-1:0], got);

		// upper halves must not reach a MUL_W product.
		run_reference("mulw upper a", MUL_W, 64'h1234_5678_8000_0003, 64'hdead_beef_ffff_fff9);
		run_reference("mulw upper b", MUL_W, 64'h0000_0000_8000_0003, 64'h7777_0000_ffff_fff9);

		start_product(MUL_LO, 64'd9, 64'd7);
		wb_write(ADR_CTRL, control_word(MUL_LO, 1'b0, 1'b1));
		wb_read(ADR_STATUS, got);
		check("status after flush", '0, got);
		run_reference("after flush", MUL_LO, 64'd11, 64'd13);

		for (int i = 0; i < NUM_RAND; i++) begin
			a   = {$random(seed), $random(seed)};
			b   = {$random(seed), $random(seed)};
			opc = (i % 2 == 0) ? MUL_HUU : MUL_HSS;
			run_reference($sformatf("random %0d", i), opc, a, b);
		end

		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: dv/mul_trace.txt
# name opcode op1 op2 exp_hi exp_lo (operands and results in hex)
# opcode 0 MUL_LO, 1 MUL_HSS, 2 MUL_HSU, 3 MUL_HUU, 4 MUL_W
zero_lo 0 0000000000000000 0000000000001234 0000000000000000 0000000000000000
zero_huu 3 0000000000000000 ffffffffffffffff 0000000000000000 0000000000000000
one_lo 0 0000000000000001 0123456789abcdef 0000000000000000 0123456789abcdef
neg1_lo 0 ffffffffffffffff 0000000000000005 ffffffffffffffff fffffffffffffffb
neg1_sq_hss 1 ffffffffffffffff ffffffffffffffff 0000000000000000 0000000000000001
neg1_hsu 2 ffffffffffffffff ffffffffffffffff ffffffffffffffff 0000000000000001
allones_huu 3 ffffffffffffffff ffffffffffffffff fffffffffffffffe 0000000000000001
minneg_sq_hss 1 8000000000000000 8000000000000000 4000000000000000 0000000000000000
minneg_neg1_hss 1 8000000000000000 ffffffffffffffff 0000000000000000 8000000000000000
minneg_huu 3 8000000000000000 8000000000000000 4000000000000000 0000000000000000
minneg_hsu 2 8000000000000000 ffffffffffffffff 8000000000000000 8000000000000000
mixed_hss 1 0000000000000007 fffffffffffffffd ffffffffffffffff ffffffffffffffeb
mixed_hsu 2 fffffffffffffffe 0000000000000003 ffffffffffffffff fffffffffffffffa
mixed_hsu_big 2 0000000000000003 8000000000000000 0000000000000001 8000000000000000
mixed_huu 3 fffffffffffffffe 0000000000000003 0000000000000002 fffffffffffffffa
carry_lo 0 0000000100000000 0000000100000000 0000000000000001 0000000000000000
maxpos_hss 1 7fffffffffffffff 0000000000000002 0000000000000000 fffffffffffffffe
shift_hss 1 0000000000010000 fffffffffffffff0 ffffffffffffffff fffffffffff00000
halves_huu 3 00000000ffffffff 00000000ffffffff 0000000000000000 fffffffe00000001
mulw_basic 4 ffffffff00000005 1234567800000003 0000000000000000 000000000000000f
mulw_neg 4 00000000ffffffff abcdef0000000007 ffffffffffffffff fffffffffffffff9
mulw_min 4 0000000080000000 0000000080000000 0000000000000000 4000000000000000
mulw_mixed 4 1111111180000000 2222222200000002 ffffffffffffffff ffffffff00000000

// File: sim.f
src/mul_pkg.sv
src/booth_encoder.sv
src/wallace_tree.sv
src/mul_core.sv
src/mul_wb_regs.sv
src/mul_top.sv
dv/mul_tb.sv

// File: src/booth_encoder.sv
`timescale 1ns/10ps

module booth_encoder #(
	parameter int XLEN = 64
) (
	input  logic [XLEN+2:0]                    multiplicand,
	input  logic [XLEN+2:0]                    multiplier,
	output logic [(XLEN/2+1)*2*XLEN-1:0]       part_prod,
	output logic [XLEN/2:0]                    part_neg
);

	localparam int NPP = XLEN / 2 + 1;
	localparam int W   = 2 * XLEN;

	logic [W-1:0] mcand_w;

	// the product is taken modulo 2^W, so the multiplicand is widened to W once.
	assign mcand_w = {{(W-XLEN-3){multiplicand[XLEN+2]}}, multiplicand};

	for (genvar i = 0; i < NPP; i++) begin : g_pp
		logic [2:0]   trip;
		logic         one;
		logic         two;
		logic         neg;
		logic [W-1:0] sel;
		logic [W-1:0] val;

		assign trip = multiplier[2*i+2:2*i];

		// digit recoding, 111 is a zero digit and never negates.
		assign one = trip[0] ^ trip[1];
		assign two = (trip == 3'b011) | (trip == 3'b100);
		assign neg = trip[2] & ~(trip[1] & trip[0]);

		always_comb begin
			if (one) begin
				sel = mcand_w;
			end else if (two) begin
				sel = {mcand_w[W-2:0], 1'b0};
			end else begin
				sel = '0;
			end
		end

		// invert before shifting so the +1 lands at column 2i.
		assign val = neg ? ~sel : sel;

		assign part_prod[i*W +: W] = val << (2 * i);
		assign part_neg[i]         = neg;
	end

endmodule

// File: src/mul_core.sv
`timescale 1ns/10ps

module mul_core #(
	parameter int XLEN = 64
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  logic                flush,
	input  mul_pkg::mul_op_e    op,
	input  logic [XLEN-1:0]     op1,
	input  logic [XLEN-1:0]     op2,
	output logic                done,
	output logic [XLEN-1:0]     prod_hi,
	output logic [XLEN-1:0]     prod_lo
);
	import mul_pkg::*;

	localparam int NPP  = XLEN / 2 + 1;
	localparam int W    = 2 * XLEN;
	localparam int HALF = XLEN / 2;

	logic [XLEN-1:0]  a_src;
	logic [XLEN-1:0]  b_src;
	logic             a_sgn;
	logic             b_sgn;
	logic [XLEN+1:0]  a_ext;
	logic [XLEN+1:0]  b_ext;
	logic [XLEN+2:0]  mcand;
	logic [XLEN+2:0]  mplier;
	logic [NPP*W-1:0] part_prod;
	logic [NPP-1:0]   part_neg;
	logic [NPP*W-1:0] pp_q;
	logic [NPP-1:0]   neg_q;
	logic [W-1:0]     row_sum;
	logic [W-1:0]     row_carry;
	logic             cin;
	logic [W-1:0]     sum_q;
	logic [W-1:0]     carry_q;
	logic             cin_q;
	logic             v1;
	logic             v2;
	logic             v3;
	logic [W-1:0]     prod;

	always_comb begin
		a_src = op1;
		b_src = op2;
		a_sgn = 1'b1;
		b_sgn = 1'b1;
		case (op)
			MUL_W: begin
				a_src = {{HALF{op1[HALF-1]}}, op1[HALF-1:0]};
				b_src = {{HALF{op2[HALF-1]}}, op2[HALF-1:0]};
			end
			MUL_HSU: b_sgn = 1'b0;
			MUL_HUU: begin
				a_sgn = 1'b0;
				b_sgn = 1'b0;
			end
			default: ;
		endcase
	end

	// two extra bits keep unsigned operands positive under Booth recoding.
	assign a_ext  = {{2{a_sgn & a_src[XLEN-1]}}, a_src};
	assign b_ext  = {{2{b_sgn & b_src[XLEN-1]}}, b_src};
	assign mcand  = {a_ext[XLEN+1], a_ext};
	assign mplier = {b_ext, 1'b0};

	booth_encoder #(.XLEN(XLEN)) booth_i (
		.multiplicand (mcand),
		.multiplier   (mplier),
		.part_prod    (part_prod),
		.part_neg     (part_neg)
	);

	// stage 1 captures the partial products on start only.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pp_q  <= '0;
			neg_q <= '0;
		end else if (flush) begin
			pp_q  <= '0;
			neg_q <= '0;
		end else if (start) begin
			pp_q  <= part_prod;
			neg_q <= part_neg;
		end
	end

	wallace_tree #(.XLEN(XLEN)) tree_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.part_prod (pp_q),
		.part_neg  (neg_q),
		.row_sum   (row_sum),
		.row_carry (row_carry),
		.cin       (cin)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum_q   <= '0;
			carry_q <= '0;
			cin_q   <= 1'b0;
		end else if (flush) begin
			sum_q   <= '0;
			carry_q <= '0;
			cin_q   <= 1'b0;
		end else begin
			sum_q   <= row_sum;
			carry_q <= row_carry;
			cin_q   <= cin;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
		end else if (flush) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
		end else begin
			v1 <= start;
			v2 <= v1;
			v3 <= v2;
		end
	end

	assign prod    = sum_q + carry_q + {{(W-1){1'b0}}, cin_q};
	assign done    = v3;
	assign prod_hi = prod[W-1:XLEN];
	assign prod_lo = prod[XLEN-1:0];

endmodule

// File: src/mul_pkg.sv
package mul_pkg;

	// RISC-V M extension multiply variants.
	typedef enum logic [2:0] {
		MUL_LO  = 3'd0,
		MUL_HSS = 3'd1,
		MUL_HSU = 3'd2,
		MUL_HUU = 3'd3,
		MUL_W   = 3'd4
	} mul_op_e;

	// bus-side view of the multiply in progress.
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		BUSY = 2'd1,
		DONE = 2'd2
	} wb_state_e;

	// register byte offsets on the Wishbone port.
	localparam logic [5:0] ADR_OP1    = 6'h00;
	localparam logic [5:0] ADR_OP2    = 6'h08;
	localparam logic [5:0] ADR_CTRL   = 6'h10;
	localparam logic [5:0] ADR_RES_LO = 6'h18;
	localparam logic [5:0] ADR_RES_HI = 6'h20;
	localparam logic [5:0] ADR_STATUS = 6'h28;

	// control word layout, opcode sits in bits 2:0.
	localparam int CTRL_START = 3;
	localparam int CTRL_FLUSH = 4;

endpackage

// File: src/mul_top.sv
`timescale 1ns/10ps

module mul_top #(
	parameter int XLEN = 64
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            wb_cyc,
	input  logic            wb_stb,
	input  logic            wb_we,
	input  logic [5:0]      wb_adr,
	input  logic [XLEN-1:0] wb_dat_w,
	output logic [XLEN-1:0] wb_dat_r,
	output logic            wb_ack
);
	import mul_pkg::*;

	logic            start;
	logic            flush;
	mul_op_e         op;
	logic [XLEN-1:0] op1;
	logic [XLEN-1:0] op2;
	logic            done;
	logic [XLEN-1:0] prod_hi;
	logic [XLEN-1:0] prod_lo;

	mul_wb_regs #(.XLEN(XLEN)) regs_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.start    (start),
		.flush    (flush),
		.op       (op),
		.op1      (op1),
		.op2      (op2),
		.done     (done),
		.prod_hi  (prod_hi),
		.prod_lo  (prod_lo)
	);

	mul_core #(.XLEN(XLEN)) core_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.flush   (flush),
		.op      (op),
		.op1     (op1),
		.op2     (op2),
		.done    (done),
		.prod_hi (prod_hi),
		.prod_lo (prod_lo)
	);

endmodule

// File: src/mul_wb_regs.sv
`timescale 1ns/10ps

module mul_wb_regs #(
	parameter int XLEN = 64
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  logic [5:0]          wb_adr,
	input  logic [XLEN-1:0]     wb_dat_w,
	output logic [XLEN-1:0]     wb_dat_r,
	output logic                wb_ack,
	output logic                start,
	output logic                flush,
	output mul_pkg::mul_op_e    op,
	output logic [XLEN-1:0]     op1,
	output logic [XLEN-1:0]     op2,
	input  logic                done,
	input  logic [XLEN-1:0]     prod_hi,
	input  logic [XLEN-1:0]     prod_lo
);
	import mul_pkg::*;

	wb_state_e       state;
	logic [XLEN-1:0] res_lo;
	logic [XLEN-1:0] res_hi;
	logic [XLEN-1:0] rd_data;
	logic            req;
	logic            stall;
	logic            acc;
	logic            ctrl_wr;
	logic            go;

	assign req = wb_cyc & wb_stb & ~wb_ack;

	// result reads wait here until the product has been captured.
	assign stall = ~wb_we & (state == BUSY) &
		((wb_adr == ADR_RES_LO) | (wb_adr == ADR_RES_HI));

	assign acc     = req & ~stall;
	assign ctrl_wr = acc & wb_we & (wb_adr == ADR_CTRL);
	assign go      = ctrl_wr & wb_dat_w[CTRL_START] & ~wb_dat_w[CTRL_FLUSH] & (state != BUSY);

	always_comb begin
		rd_data = '0;
		case (wb_adr)
			ADR_OP1:    rd_data = op1;
			ADR_OP2:    rd_data = op2;
			ADR_CTRL:   rd_data = {{(XLEN-3){1'b0}}, op};
			ADR_RES_LO: rd_data = res_lo;
			ADR_RES_HI: rd_data = res_hi;
			ADR_STATUS: rd_data[1:0] = {state == DONE, state == BUSY};
			default:    rd_data = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack   <= 1'b0;
			wb_dat_r <= '0;
			start    <= 1'b0;
			flush    <= 1'b0;
		end else begin
			wb_ack <= acc;
			start  <= go;
			flush  <= ctrl_wr & wb_dat_w[CTRL_FLUSH];
			if (acc && !wb_we) begin
				wb_dat_r <= rd_data;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op1 <= '0;
			op2 <= '0;
			op  <= MUL_LO;
		end else begin
			if (acc && wb_we && wb_adr == ADR_OP1) begin
				op1 <= wb_dat_w;
			end
			if (acc && wb_we && wb_adr == ADR_OP2) begin
				op2 <= wb_dat_w;
			end
			if (go) begin
				op <= mul_op_e'(wb_dat_w[2:0]);
			end
		end
	end

	// flush wins over start; a done seen outside BUSY is stale.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= IDLE;
			res_lo <= '0;
			res_hi <= '0;
		end else if (ctrl_wr && wb_dat_w[CTRL_FLUSH]) begin
			state <= IDLE;
		end else if (go) begin
			state <= BUSY;
		end else if (state == BUSY && done) begin
			state  <= DONE;
			res_lo <= prod_lo;
			res_hi <= prod_hi;
		end
	end

endmodule

// File: src/wallace_tree.sv
`timescale 1ns/10ps

module wallace_tree #(
	parameter int XLEN = 64
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               flush,
	input  logic [(XLEN/2+1)*2*XLEN-1:0]       part_prod,
	input  logic [XLEN/2:0]                    part_neg,
	output logic [2*XLEN-1:0]                  row_sum,
	output logic [2*XLEN-1:0]                  row_carry,
	output logic                               cin
);

	localparam int NPP  = XLEN / 2 + 1;
	localparam int W    = 2 * XLEN;
	localparam int NROW = NPP + 1;

	function automatic int rows_at(input int lvl);
		int n;
		n = NROW;
		for (int k = 0; k < lvl; k++) begin
			n = (n / 3) * 2 + n % 3;
		end
		return n;
	endfunction

	function automatic int num_levels();
		int n;
		int l;
		n = NROW;
		l = 0;
		while (n > 2) begin
			n = (n / 3) * 2 + n % 3;
			l = l + 1;
		end
		return l;
	endfunction

	localparam int NLVL = num_levels();
	localparam int MID  = NLVL / 2;

	logic [W-1:0] stage [0:NLVL][0:NROW-1];
	logic [W-1:0] neg_row;

	// negation carries 1.. go into one extra row; carry 0 becomes cin.
	always_comb begin
		neg_row = '0;
		for (int i = 1; i < NPP; i++) begin
			neg_row[2*i] = part_neg[i];
		end
	end

	for (genvar r = 0; r < NPP; r++) begin : g_in
		assign stage[0][r] = part_prod[r*W +: W];
	end
	assign stage[0][NPP] = neg_row;

	for (genvar l = 0; l < NLVL; l++) begin : g_lvl
		localparam int NIN  = rows_at(l);
		localparam int NOUT = rows_at(l + 1);
		localparam int NGRP = NIN / 3;
		localparam int NREM = NIN % 3;

		logic [W-1:0] nxt [0:NOUT-1];

		for (genvar g = 0; g < NGRP; g++) begin : g_csa
			logic [W-1:0] a;
			logic [W-1:0] b;
			logic [W-1:0] c;
			logic [W-1:0] maj;

			assign a   = stage[l][3*g];
			assign b   = stage[l][3*g+1];
			assign c   = stage[l][3*g+2];
			assign maj = (a & b) | (a & c) | (b & c);

			assign nxt[2*g]   = a ^ b ^ c;
			assign nxt[2*g+1] = {maj[W-2:0], 1'b0};
		end

		for (genvar r = 0; r < NREM; r++) begin : g_pass
			assign nxt[2*NGRP+r] = stage[l][3*NGRP+r];
		end

		for (genvar j = 0; j < NOUT; j++) begin : g_row
			if (l + 1 == MID) begin : g_ff
				logic [W-1:0] q;

				// pipeline stage 2.
				always_ff @(posedge clk or negedge rst_n) begin
					if (!rst_n) begin
						q <= '0;
					end else if (flush) begin
						q <= '0;
					end else begin
						q <= nxt[j];
					end
				end
				assign stage[l+1][j] = q;
			end else begin : g_wire
				assign stage[l+1][j] = nxt[j];
			end
		end

		for (genvar j = NOUT; j < NROW; j++) begin : g_zero
			assign stage[l+1][j] = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cin <= 1'b0;
		end else if (flush) begin
			cin <= 1'b0;
		end else begin
			cin <= part_neg[0];
		end
	end

	assign row_sum   = stage[NLVL][0];
	assign row_carry = stage[NLVL][1];

endmodule
